// File: design/hp_semaphore.sv
`timescale 1ns/1ns

module hp_semaphore import sem_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [num_channels-1:0] acq,
	input  logic [num_channels-1:0] rel,
	output logic [num_channels-1:0] free,
	output logic                    busy
);

	// One-hot owner chosen by the arbiter
	logic [num_channels-1:0] sel;

	// High when the current owner asks to release
	logic owner_rel;

	// The arbiter only moves while the semaphore is free
	// Once it is taken the owner stays put, even after a release,
	// until the next acquire round starts
	round_robin_arbiter u_arb (
		.clk (clk),
		.rst (rst),
		.ce  (~busy),
		.req (acq),
		.sel (sel)
	);

	// Releases from anyone but the selected channel are ignored
	assign owner_rel = |(rel & sel);

	// ======================================================================
	// Busy flag
	// ======================================================================

	// Any acquire sets the flag and wins over a release in the same cycle
	always_ff @(posedge clk) begin
		if (rst)
			busy <= 1'b0;
		else if (|acq)
			busy <= 1'b1;
		else if (owner_rel)
			busy <= 1'b0;
	end

	// Only the selected channel sees the semaphore as free
	// every other channel sees it taken
	assign free = sel;

	// A set flag only drops after the owner released on the edge before
	busy_clear_by_owner: assert property (@(posedge clk) disable iff (rst)
		!$past(rst) && $fell(busy) |-> $past(owner_rel));

	// An acquire always leaves the flag set on the following cycle
	busy_held_on_acq: assert property (@(posedge clk) disable iff (rst)
		|acq |=> busy);

endmodule

// File: design/round_robin_arbiter.sv
`timescale 1ns/1ns

module round_robin_arbiter import sem_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    ce,
	input  logic [num_channels-1:0] req,
	output logic [num_channels-1:0] sel
);

	// Encoded form of the current one-hot selection
	logic [ch_idx_w-1:0] cur_idx;

	// Selection that the next enabled edge would load
	logic [num_channels-1:0] nxt_sel;

	// ======================================================================
	// Next selection search
	// ======================================================================

	// Turn the one-hot register into an index so the search can start after it
	always_comb begin
		cur_idx = '0;
		for (int i = 0; i < num_channels; i++) begin
			if (sel[i])
				cur_idx = ch_idx_w'(i);
		end
	end

	// Walk upward from the channel after the current one and wrap around
	// The current channel is tried last, so a lone requester keeps its grant
	always_comb begin
		int  pos;
		logic found;
		nxt_sel = sel;
		found = 1'b0;
		for (int i = 1; i <= num_channels; i++) begin
			pos = (int'(cur_idx) + i) % num_channels;
			if (!found && req[pos]) begin
				nxt_sel = '0;
				nxt_sel[pos] = 1'b1;
				found = 1'b1;
			end
		end
	end

	// ======================================================================
	// Selection register
	// ======================================================================

	// Channel 0 holds the grant out of reset
	// Without requests or enable the old choice is kept
	always_ff @(posedge clk) begin
		if (rst)
			sel <= num_channels'(1);
		else if (ce && |req)
			sel <= nxt_sel;
	end

	// Exactly one channel is ever selected, even across many rotations
	sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot(sel));

endmodule

// File: design/sem_cmd_decode.sv
`timescale 1ns/1ns

module sem_cmd_decode import sem_pkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	input  sem_cmd_t [num_channels-1:0]  cmd,
	output sem_cmd_t [num_channels-1:0]  cmd_q,
	output sem_req_t                     req
);

	// ======================================================================
	// Stage 1 command register
	// ======================================================================

	// Every channel is sampled each cycle with no hold or stall
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int c = 0; c < num_channels; c++) begin
				cmd_q[c].op  <= op_nop;
				cmd_q[c].sem <= '0;
			end
		end else begin
			cmd_q <= cmd;
		end
	end

	// ======================================================================
	// Fan out to semaphore rows
	// ======================================================================

	// Each registered command lands in the row of the semaphore it names
	// Probes and nops only travel on to the response stage
	always_comb begin
		req = '0;
		for (int c = 0; c < num_channels; c++) begin
			case (cmd_q[c].op)
				op_acquire: req.acq[cmd_q[c].sem][c] = 1'b1;
				op_release: req.rel[cmd_q[c].sem][c] = 1'b1;
				default: ;
			endcase
		end
	end

	// Several channels may hit one semaphore in the same cycle
	// and the semaphore's arbiter sorts that out, so nothing is
	// filtered here

endmodule

// File: design/sem_pkg.sv
package sem_pkg;

	// ======================================================================
	// Sizes
	// ======================================================================

	// Requester channels that share the semaphore block
	localparam int num_channels = 4;

	// Hardware semaphores in the unit
	localparam int num_sems = 4;

	// Width of a semaphore index carried in a command
	localparam int sem_idx_w = $clog2(num_sems);

	// Width of an encoded channel number inside the arbiter
	localparam int ch_idx_w = $clog2(num_channels);

	// ======================================================================
	// Opcodes
	// ======================================================================

	// Nop must stay at zero because reset values rely on it
	typedef enum logic [1:0] {
		op_nop     = 2'd0,
		op_acquire = 2'd1,
		op_release = 2'd2,
		op_probe   = 2'd3
	} sem_op_e;

	// ======================================================================
	// Structs
	// ======================================================================

	// One channel's command, presented as a single-cycle strobe
	typedef struct packed {
		sem_op_e              op;
		logic [sem_idx_w-1:0] sem;
	} sem_cmd_t;

	// Decoded requests for the whole unit
	// Row s holds one bit per channel for semaphore s
	typedef struct packed {
		logic [num_sems-1:0][num_channels-1:0] acq;
		logic [num_sems-1:0][num_channels-1:0] rel;
	} sem_req_t;

	// One channel's response
	// Owner is set when this channel is the one the semaphore considers free
	typedef struct packed {
		logic    valid;
		sem_op_e op;
		logic    owner;
	} sem_resp_t;

endpackage

// File: design/sem_status_return.sv
`timescale 1ns/1ns

module sem_status_return import sem_pkg::*; (
	input  logic                                  clk,
	input  logic                                  rst,
	input  sem_cmd_t [num_channels-1:0]           cmd_q,
	input  logic [num_sems-1:0][num_channels-1:0] free,
	output sem_resp_t [num_channels-1:0]          resp
);

	// Commands one stage later, aligned with the updated semaphore state
	sem_cmd_t [num_channels-1:0] cmd_d;

	// Owner bit picked from the row of the addressed semaphore
	logic [num_channels-1:0] owner;

	// Valid bits gathered for the reset check
	logic [num_channels-1:0] valid_vec;

	// ======================================================================
	// Alignment delay
	// ======================================================================

	// The semaphores update on the same edge that loads this register,
	// so cmd_d and free describe the same point in time
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int c = 0; c < num_channels; c++) begin
				cmd_d[c].op  <= op_nop;
				cmd_d[c].sem <= '0;
			end
		end else begin
			cmd_d <= cmd_q;
		end
	end

	// Look up this channel's column in the addressed semaphore's row
	always_comb begin
		for (int c = 0; c < num_channels; c++) begin
			owner[c]     = free[cmd_d[c].sem][c];
			valid_vec[c] = resp[c].valid;
		end
	end

	// ======================================================================
	// Stage 3 response register
	// ======================================================================

	// One strobe per command and none for a nop
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int c = 0; c < num_channels; c++) begin
				resp[c].valid <= 1'b0;
				resp[c].op    <= op_nop;
				resp[c].owner <= 1'b0;
			end
		end else begin
			for (int c = 0; c < num_channels; c++) begin
				resp[c].valid <= (cmd_d[c].op != op_nop);
				resp[c].op    <= cmd_d[c].op;
				resp[c].owner <= owner[c];
			end
		end
	end

	// Nothing can come out in the cycle after reset since the pipe is flushed
	no_resp_after_rst: assert property (@(posedge clk) rst |=> valid_vec == '0);

endmodule

// File: design/sem_unit.sv
`timescale 1ns/1ns

module sem_unit import sem_pkg::*; (
	input  logic                         clk,
	input  logic                         rst,
	input  sem_cmd_t [num_channels-1:0]  cmd,
	output sem_resp_t [num_channels-1:0] resp,
	output logic [num_sems-1:0]          sem_busy
);

	// ======================================================================
	// Pipeline wiring
	// ======================================================================

	// Registered commands leaving stage 1
	sem_cmd_t [num_channels-1:0] cmd_q;

	// Per-semaphore acquire and release rows from stage 1
	sem_req_t req;

	// Free view of every semaphore, one row per semaphore
	logic [num_sems-1:0][num_channels-1:0] free;

	// ======================================================================
	// Stage 1, command decode
	// ======================================================================

	// Commands held across an edge are captured there and decoded into rows
	sem_cmd_decode u_decode (
		.clk   (clk),
		.rst   (rst),
		.cmd   (cmd),
		.cmd_q (cmd_q),
		.req   (req)
	);

	// ======================================================================
	// Stage 2, semaphore state
	// ======================================================================

	// Each semaphore only ever sees its own row
	// so traffic to one cannot disturb another
	for (genvar s = 0; s < num_sems; s++) begin : g_sem
		hp_semaphore u_sem (
			.clk  (clk),
			.rst  (rst),
			.acq  (req.acq[s]),
			.rel  (req.rel[s]),
			.free (free[s]),
			.busy (sem_busy[s])
		);
	end

	// ======================================================================
	// Stage 3, response return
	// ======================================================================

	// Responses appear three edges after the command was presented
	// and last for a single cycle
	sem_status_return u_return (
		.clk   (clk),
		.rst   (rst),
		.cmd_q (cmd_q),
		.free  (free),
		.resp  (resp)
	);

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the semaphore unit testbench with Verilator.
# Exits non-zero if the build fails, the simulation fails, or the log
# reports failed checks.

set -u

cd "$(dirname "$0")" || exit 1

log_file="sim.log"
build_dir="obj_dir"
sim_bin="sem_unit_sim"

# Compile the RTL and the testbench into a simulation binary
verilator --binary --timing --assert -Wno-fatal \
	-f sem_unit.f \
	--top-module sem_unit_tb \
	-Mdir "${build_dir}" \
	-o "${sim_bin}"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Run the simulation and keep its output
"./${build_dir}/${sim_bin}" > "${log_file}" 2>&1
sim_status=$?
cat "${log_file}"
if [ ${sim_status} -ne 0 ]; then
	echo "Simulation exited with status ${sim_status}"
	exit 1
fi

# Pass or fail comes from the log
if grep -q "CHECKS FAILED" "${log_file}"; then
	echo "Simulation reported failures"
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "${log_file}"; then
	echo "Simulation ended without a pass message"
	exit 1
fi

exit 0

// File: sem_unit.f
design/sem_pkg.sv
design/round_robin_arbiter.sv
design/hp_semaphore.sv
design/sem_cmd_decode.sv
design/sem_status_return.sv
design/sem_unit.sv
verif/sem_unit_tb.sv

// File: verif/sem_unit_tb.sv
`timescale 1ns/1ns

module sem_unit_tb import sem_pkg::*; ();

	// ======================================================================
	// Run sizes
	// ======================================================================

	localparam int tbl_len = 19;
	localparam int rand_cycles = 200;
	localparam int total_rows = tbl_len + rand_cycles;
	// Edges from a command to its response, and from a command to its busy flag
	localparam int resp_lag = 3;
	localparam int busy_lag = 2;
	localparam int timeout_cycles = tbl_len + rand_cycles + 20;
	localparam int unsigned lcg_seed = 54927;

	logic                         clk;
	logic                         rst;
	sem_cmd_t [num_channels-1:0]  cmd;
	sem_resp_t [num_channels-1:0] resp;
	logic [num_sems-1:0]          sem_busy;

	// Directed rows where owner bit c belongs to channel c
	sem_cmd_t [num_channels-1:0] tbl_cmd [tbl_len];
	logic [num_channels-1:0]     tbl_owner [tbl_len];
	logic [num_sems-1:0]         tbl_busy [tbl_len];
	string                       tbl_name [tbl_len];
	int                          n_rows;

	// Expected values for every issued row, read back when the pipe delivers
	sem_resp_t [num_channels-1:0] exp_resp [total_rows];
	logic [num_sems-1:0]          exp_busy [total_rows];
	string                        row_name [total_rows];

	// Reference model of the flags and arbiter selections
	logic [num_sems-1:0] m_busy;
	int                  m_sel [num_sems];

	int unsigned rng_state;
	int          err_resp;
	int          err_busy;
	int          err_misc;
	int          cycle_cnt;

	sem_unit uut (
		.clk      (clk),
		.rst      (rst),
		.cmd      (cmd),
		.resp     (resp),
		.sem_busy (sem_busy)
	);

	always #10 clk = ~clk;

	// Watchdog in case the main sequence stalls
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt > timeout_cycles) begin
			$display("run timed out after %0d cycles", cycle_cnt);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// ======================================================================
	// Command helpers
	// ======================================================================

	function automatic sem_cmd_t make_cmd(sem_op_e op, int s);
		sem_cmd_t c;
		c.op = op;
		c.sem = sem_idx_w'(s);
		return c;
	endfunction

	function automatic sem_cmd_t acq_cmd(int s);
		return make_cmd(op_acquire, s);
	endfunction

	function automatic sem_cmd_t rel_cmd(int s);
		return make_cmd(op_release, s);
	endfunction

	function automatic sem_cmd_t prb_cmd(int s);
		return make_cmd(op_probe, s);
	endfunction

	function automatic sem_cmd_t nop_cmd();
		return make_cmd(op_nop, 0);
	endfunction

	// Response that a channel should see for a command and an owner bit
	function automatic sem_resp_t expect_resp(sem_cmd_t c, logic owner);
		sem_resp_t r;
		r.valid = (c.op != op_nop);
		r.op = c.op;
		r.owner = owner;
		return r;
	endfunction

	// LCG with the classic C library constants
	function automatic int unsigned lcg_next(int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic draw_random(output sem_cmd_t [num_channels-1:0] c);
		for (int ch = 0; ch < num_channels; ch++) begin
			rng_state = lcg_next(rng_state);
			// Upper bits of the LCG are the better mixed ones
			c[ch].op = sem_op_e'(rng_state[17:16]);
			c[ch].sem = rng_state[20 +: sem_idx_w];
		end
	endtask

	// ======================================================================
	// Reference model
	// ======================================================================

	// One clock edge of all semaphores, then the owner view per channel
	task automatic model_step(input sem_cmd_t [num_channels-1:0] c,
			output logic [num_channels-1:0] owner);
		logic [num_channels-1:0] acq_v;
		logic [num_channels-1:0] rel_v;
		int                      old_sel;
		int                      pos;
		logic                    found;
		for (int s = 0; s < num_sems; s++) begin
			acq_v = '0;
			rel_v = '0;
			for (int ch = 0; ch < num_channels; ch++) begin
				if (int'(c[ch].sem) == s && c[ch].op == op_acquire)
					acq_v[ch] = 1'b1;
				if (int'(c[ch].sem) == s && c[ch].op == op_release)
					rel_v[ch] = 1'b1;
			end
			old_sel = m_sel[s];
			found = 1'b0;
			// Arbiter moves only while the flag was clear before the edge
			if (!m_busy[s] && acq_v != '0) begin
				for (int i = 1; i <= num_channels; i++) begin
					pos = (old_sel + i) % num_channels;
					if (!found && acq_v[pos]) begin
						m_sel[s] = pos;
						found = 1'b1;
					end
				end
			end
			// Acquire beats an owner release in the same cycle
			if (acq_v != '0)
				m_busy[s] = 1'b1;
			else if (rel_v[old_sel])
				m_busy[s] = 1'b0;
		end
		for (int ch = 0; ch < num_channels; ch++)
			owner[ch] = (m_sel[c[ch].sem] == ch);
	endtask

	// ======================================================================
	// Compare tasks
	// ======================================================================

	// A nop has no meaningful owner bit so only its valid bit is checked
	task automatic check_resp(input string name, input int row, input int ch,
			input sem_resp_t exp, input sem_resp_t act);
		logic bad;
		if (exp.valid)
			bad = (act !== exp);
		else
			bad = (act.valid !== 1'b0);
		if (bad) begin
			err_resp++;
			$write("error %s row %0d ch %0d: expected valid %b op %0d owner %b",
				name, row, ch, exp.valid, exp.op, exp.owner);
			$display(", actual valid %b op %0d owner %b", act.valid, act.op, act.owner);
		end
	endtask

	task automatic check_busy(input string name, input int row,
			input logic [num_sems-1:0] exp, input logic [num_sems-1:0] act);
		if (act !== exp) begin
			err_busy++;
			$display("error %s row %0d: expected busy %b actual busy %b", name, row, exp, act);
		end
	endtask

	// ======================================================================
	// Directed table
	// ======================================================================

	task automatic add_row(input string name, input sem_cmd_t c0, input sem_cmd_t c1,
			input sem_cmd_t c2, input sem_cmd_t c3,
			input logic [num_channels-1:0] owner, input logic [num_sems-1:0] busy);
		tbl_cmd[n_rows] = {c3, c2, c1, c0};
		tbl_owner[n_rows] = owner;
		tbl_busy[n_rows] = busy;
		tbl_name[n_rows] = name;
		n_rows++;
	endtask

	// Columns are channels 0 to 3, then owner and busy with bit 0 on the right
	task automatic fill_table();
		add_row("reset_idle", nop_cmd(), nop_cmd(), nop_cmd(), nop_cmd(), 4'b0000, 4'b0000);
		add_row("reset_idle", nop_cmd(), nop_cmd(), nop_cmd(), nop_cmd(), 4'b0000, 4'b0000);
		// Channel 1 takes semaphore 0, then channel 2 is turned away
		add_row("single_acquire", nop_cmd(), acq_cmd(0), nop_cmd(), nop_cmd(), 4'b0010, 4'b0001);
		add_row("single_acquire", nop_cmd(), nop_cmd(), acq_cmd(0), nop_cmd(), 4'b0000, 4'b0001);
		add_row("single_acquire", nop_cmd(), prb_cmd(0), nop_cmd(), nop_cmd(), 4'b0010, 4'b0001);
		// A stranger's release is ignored while the owner's clears the flag
		add_row("release", nop_cmd(), nop_cmd(), nop_cmd(), rel_cmd(0), 4'b0000, 4'b0001);
		add_row("release", nop_cmd(), rel_cmd(0), nop_cmd(), nop_cmd(), 4'b0010, 4'b0000);
		// Rounds on semaphore 1 rotate the winner from channel 1 onward
		add_row("contended_acquire", acq_cmd(1), acq_cmd(1), acq_cmd(1), acq_cmd(1),
			4'b0010, 4'b0010);
		add_row("contended_acquire", nop_cmd(), rel_cmd(1), nop_cmd(), nop_cmd(), 4'b0010, 4'b0000);
		add_row("contended_acquire", acq_cmd(1), acq_cmd(1), acq_cmd(1), acq_cmd(1),
			4'b0100, 4'b0010);
		add_row("contended_acquire", nop_cmd(), nop_cmd(), rel_cmd(1), nop_cmd(), 4'b0100, 4'b0000);
		add_row("contended_acquire", acq_cmd(1), nop_cmd(), nop_cmd(), acq_cmd(1), 4'b1000, 4'b0010);
		add_row("contended_acquire", nop_cmd(), nop_cmd(), nop_cmd(), rel_cmd(1), 4'b1000, 4'b0000);
		add_row("contended_acquire", acq_cmd(1), acq_cmd(1), nop_cmd(), nop_cmd(), 4'b0001, 4'b0010);
		// Owner release plus a new acquire keeps the flag and the old owner
		add_row("acquire_wins", rel_cmd(1), nop_cmd(), acq_cmd(1), nop_cmd(), 4'b0001, 4'b0010);
		add_row("acquire_wins", prb_cmd(1), nop_cmd(), prb_cmd(1), nop_cmd(), 4'b0001, 4'b0010);
		// Mixed traffic across all four semaphores
		add_row("isolation", acq_cmd(2), acq_cmd(3), rel_cmd(1), prb_cmd(0), 4'b0011, 4'b1110);
		add_row("isolation", rel_cmd(1), rel_cmd(3), prb_cmd(2), nop_cmd(), 4'b0011, 4'b0100);
		add_row("isolation", rel_cmd(2), nop_cmd(), rel_cmd(2), nop_cmd(), 4'b0001, 4'b0000);
	endtask

	// ======================================================================
	// Main sequence
	// ======================================================================

	initial begin : main
		sem_cmd_t [num_channels-1:0] next_cmd;
		logic [num_channels-1:0]     model_owner;
		logic [num_channels-1:0]     owner_v;
		clk = 1'b0;
		rst = 1'b1;
		for (int ch = 0; ch < num_channels; ch++)
			cmd[ch] = nop_cmd();
		err_resp = 0;
		err_busy = 0;
		err_misc = 0;
		cycle_cnt = 0;
		n_rows = 0;
		rng_state = lcg_seed;
		m_busy = '0;
		for (int s = 0; s < num_sems; s++)
			m_sel[s] = 0;
		fill_table();
		if (n_rows != tbl_len) begin
			err_misc++;
			$display("directed table holds %0d rows but %0d were expected", n_rows, tbl_len);
		end

		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		check_busy("after_reset", 0, '0, sem_busy);
		for (int ch = 0; ch < num_channels; ch++)
			check_resp("after_reset", 0, ch, expect_resp(nop_cmd(), 1'b0), resp[ch]);

		// Each falling edge checks older rows, then issues the next one
		for (int i = 0; i < total_rows + resp_lag; i++) begin
			@(negedge clk);
			if (i >= resp_lag) begin
				for (int ch = 0; ch < num_channels; ch++)
					check_resp(row_name[i - resp_lag], i - resp_lag, ch,
						exp_resp[i - resp_lag][ch], resp[ch]);
			end
			if (i >= busy_lag && i - busy_lag < total_rows)
				check_busy(row_name[i - busy_lag], i - busy_lag,
					exp_busy[i - busy_lag], sem_busy);
			if (i < total_rows) begin
				if (i < tbl_len)
					next_cmd = tbl_cmd[i];
				else
					draw_random(next_cmd);
				// The model follows the table too so the random phase starts in step
				model_step(next_cmd, model_owner);
				if (i < tbl_len) begin
					owner_v = tbl_owner[i];
					exp_busy[i] = tbl_busy[i];
					row_name[i] = tbl_name[i];
				end else begin
					owner_v = model_owner;
					exp_busy[i] = m_busy;
					row_name[i] = "random";
				end
				for (int ch = 0; ch < num_channels; ch++)
					exp_resp[i][ch] = expect_resp(next_cmd[ch], owner_v[ch]);
				cmd = next_cmd;
			end else begin
				for (int ch = 0; ch < num_channels; ch++)
					cmd[ch] = nop_cmd();
			end
		end

		$display("errors: resp %0d busy %0d other %0d", err_resp, err_busy, err_misc);
		if (err_resp + err_busy + err_misc == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule
